//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define ADDR_W      12                    // host word address
`define PAGE_W      4                     // word index inside a page
`define LINE_WORDS  (1 << `PAGE_W)
`define TAG_W       (`ADDR_W - `PAGE_W)   // page number

`define SLOTS       4

`define LIFE_W      8
`define LIFE_INIT   32                    // life of a freshly claimed slot
`define LIFE_LIMIT  200                   // no growth from here on
`define LIFE_STEP   (2 * `SLOTS)

`define MEM_ADDR_W  (`ADDR_W + 1)         // 16-bit halfword address

`endif

//--- cache_types_pkg.sv
`include "cache_defines.svh"

package cache_types_pkg;

  typedef logic [31:0]              word_t;
  typedef logic [15:0]              half_t;
  typedef logic [`ADDR_W-1:0]       addr_t;
  typedef logic [`TAG_W-1:0]        tag_t;
  typedef logic [`PAGE_W-1:0]       idx_t;
  typedef logic [`LIFE_W-1:0]       life_t;
  typedef logic [3:0]               be_t;
  typedef logic [`MEM_ADDR_W-1:0]   mem_addr_t;

  // enabled bytes from new_w, the rest from old_w
  function automatic word_t merge_bytes(be_t sel, word_t new_w, word_t old_w);
    word_t w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return w;
  endfunction

endpackage

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  typedef enum logic [2:0] {
    st_idle,
    st_hit,        // line_ram read latency
    st_read,       // word fetch, or bypass read
    st_wb_scan,
    st_wb_check,
    st_wb_exec,
    st_wb_done,
    st_write       // bypass write
  } ctrl_state_t;

  typedef logic [2:0] slot_t;   // 0 is no slot

  typedef enum logic [1:0] {
    cmd_none,
    cmd_read,
    cmd_write
  } mem_cmd_t;

endpackage

//--- tag_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tag_store
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  sys_rst_n,
  input  addr_t addr,
  input  slot_t slot,
  input  logic  set_tag,
  input  logic  clr_tag,
  input  logic  touch,
  output slot_t hit_slot,
  output slot_t free_slot,
  output logic  free_tag_valid,
  output tag_t  slot_tag
);
  localparam int SLOT_AW = $clog2(`SLOTS);

  tag_t               tag_q   [`SLOTS];
  logic               tag_inv [`SLOTS];
  life_t              life    [`SLOTS];
  tag_t               addr_tag;
  logic [SLOT_AW-1:0] free_sel;
  logic [SLOT_AW-1:0] cur_sel;

  assign addr_tag = addr[`ADDR_W-1:`PAGE_W];
  assign free_sel = SLOT_AW'(free_slot - 3'd1);
  assign cur_sel  = SLOT_AW'(slot - 3'd1);

  always_comb begin
    hit_slot  = '0;
    free_slot = '0;
    for (int i = `SLOTS - 1; i >= 0; i--) begin   // lowest slot wins
      if (!tag_inv[i] && tag_q[i] == addr_tag) begin
        hit_slot = slot_t'(i + 1);
      end
      if (life[i] == '0) begin
        free_slot = slot_t'(i + 1);
      end
    end
  end

  assign free_tag_valid = (free_slot != '0) && !tag_inv[free_sel];  // needs write-back scan
  assign slot_tag       = (slot != '0) ? tag_q[cur_sel] : '0;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      for (int i = 0; i < `SLOTS; i++) begin
        tag_inv[i] <= 1'b1;
        life[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < `SLOTS; i++) begin
        if (set_tag && slot == slot_t'(i + 1)) begin
          tag_inv[i] <= 1'b0;
          life[i]    <= life_t'(`LIFE_INIT);
        end else if (clr_tag && slot == slot_t'(i + 1)) begin
          tag_inv[i] <= 1'b1;                  // tag value kept for write-back
          life[i]    <= '0;
        end else if (touch) begin
          if (slot == slot_t'(i + 1)) begin
            if (life[i] < life_t'(`LIFE_LIMIT)) begin
              life[i] <= life[i] + life_t'(`LIFE_STEP);
            end
          end else if (life[i] != '0) begin
            life[i] <= life[i] - 1'b1;         // others age
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `SLOTS; i++) begin
      if (set_tag && slot == slot_t'(i + 1)) begin
        tag_q[i] <= addr_tag;
      end
    end
  end

  a_tag_excl: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(set_tag && clr_tag));

endmodule

//--- line_ram.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module line_ram
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic        clk,
  input  slot_t       slot,
  input  idx_t        ram_idx,
  input  logic        ram_we,
  input  logic        ram_merge,
  input  word_t       ram_wdata,
  input  be_t         ram_be,
  input  logic [1:0]  ram_flags,
  output logic [33:0] ram_q
);
  localparam int SLOT_AW = $clog2(`SLOTS);

  logic [33:0]        mem   [`SLOTS][`LINE_WORDS];   // {valid, dirty, word}
  logic [33:0]        q_all [`SLOTS];
  logic [SLOT_AW-1:0] sel;
  word_t              wr_word;

  // blocks power up empty, as an FPGA RAM init would leave them
  initial begin
    for (int s = 0; s < `SLOTS; s++) begin
      for (int w = 0; w < `LINE_WORDS; w++) begin
        mem[s][w] = '0;
      end
    end
  end

  assign sel     = SLOT_AW'(slot - 3'd1);
  assign ram_q   = (slot == '0) ? '0 : q_all[sel];
  assign wr_word = ram_merge ? merge_bytes(ram_be, ram_wdata, ram_q[31:0]) : ram_wdata;

  always @(posedge clk) begin
    for (int s = 0; s < `SLOTS; s++) begin
      if (ram_we && slot == slot_t'(s + 1)) begin
        mem[s][ram_idx] <= {ram_flags, wr_word};
      end
      q_all[s] <= mem[s][ram_idx];   // all slots read, slot selects after
    end
  end

  a_we_slot: assert property (@(posedge clk) ram_we |-> slot != '0);

endmodule

//--- mem_port.sv
`timescale 1ns/1ps

module mem_port
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst_n,
  input  logic      word_req,
  input  logic      word_we,
  input  addr_t     word_addr,
  input  word_t     word_data,
  input  be_t       word_be,
  output logic      word_done,
  output word_t     rd_word,
  output logic      mem_req,
  output logic      mem_we,
  output mem_addr_t mem_addr,
  output half_t     mem_wdata,
  output logic [1:0] mem_mask,
  input  half_t     mem_rdata,
  input  logic      mem_ack
);
  typedef enum logic [1:0] {
    step_idle,
    step_lo,
    step_hi
  } step_t;

  step_t    step;
  mem_cmd_t cmd;

  assign mem_req   = (cmd != cmd_none);
  assign mem_we    = (cmd == cmd_write);
  assign mem_addr  = {word_addr, 1'b0};     // low halfword, memory steps to the high one
  assign mem_wdata = (step == step_hi) ? word_data[31:16] : word_data[15:0];
  assign mem_mask  = (step == step_hi) ? ~word_be[3:2] : ~word_be[1:0];   // 1 = keep lane

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      step      <= step_idle;
      cmd       <= cmd_none;
      word_done <= 1'b0;
    end else begin
      case (step)
        step_idle: begin
          if (word_req && !word_done) begin
            cmd  <= word_we ? cmd_write : cmd_read;
            step <= step_lo;
          end
        end
        step_lo: begin
          if (mem_ack) begin
            step <= step_hi;
          end
        end
        step_hi: begin
          if (mem_ack) begin
            cmd       <= cmd_none;
            word_done <= 1'b1;
            step      <= step_idle;
          end
        end
        default: step <= step_idle;
      endcase
      if (!word_req) begin
        word_done <= 1'b0;                    // level ack follows the request down
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_ack && step == step_lo) begin
      rd_word[15:0] <= mem_rdata;
    end
    if (mem_ack && step == step_hi) begin
      rd_word[31:16] <= mem_rdata;
    end
  end

  a_ack_req: assert property (@(posedge clk) disable iff (!sys_rst_n)
    mem_ack |-> mem_req);

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        sys_rst_n,
  input  logic        read,
  input  logic        write,
  input  addr_t       addr,
  input  word_t       wdata,
  input  be_t         be,
  output word_t       rdata,
  output logic        waitrequest,
  output logic        word_req,
  output logic        word_we,
  output addr_t       word_addr,
  output word_t       word_data,
  output be_t         word_be,
  input  logic        word_done,
  input  word_t       rd_word,
  output slot_t       slot,
  output logic        set_tag,
  output logic        clr_tag,
  output logic        touch,
  input  slot_t       hit_slot,
  input  slot_t       free_slot,
  input  logic        free_tag_valid,
  input  tag_t        slot_tag,
  output logic        ram_we,
  output idx_t        ram_idx,
  output word_t       ram_wdata,
  output be_t         ram_be,
  output logic [1:0]  ram_flags,
  output logic        ram_merge,
  input  logic [33:0] ram_q
);
  localparam int FLAG_V = 33;
  localparam int FLAG_D = 32;

  ctrl_state_t state;
  logic [4:0]  wb_cnt;
  logic        read_ack;
  logic        write_ack;
  logic        full_word;
  logic        fin;

  assign waitrequest = (read && !read_ack) || (write && !write_ack);
  assign full_word   = (be == 4'hf);
  assign ram_idx     = (state inside {st_wb_scan, st_wb_check, st_wb_exec}) ?
                       wb_cnt[`PAGE_W-1:0] : addr[`PAGE_W-1:0];

  // accesses that complete this cycle
  always_comb begin
    case (state)
      st_idle:           fin = (hit_slot != '0) && write && full_word;
      st_hit:            fin = ram_q[FLAG_V] || (write && full_word);
      st_read, st_write: fin = word_done;
      default:           fin = 1'b0;
    endcase
    fin = fin && waitrequest;
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= st_idle;
      slot      <= '0;
      wb_cnt    <= '0;
      read_ack  <= 1'b0;
      write_ack <= 1'b0;
      rdata     <= '0;
      word_req  <= 1'b0;
      word_we   <= 1'b0;
      word_addr <= '0;
      word_data <= '0;
      word_be   <= '0;
      set_tag   <= 1'b0;
      clr_tag   <= 1'b0;
      touch     <= 1'b0;
      ram_we    <= 1'b0;
      ram_wdata <= '0;
      ram_be    <= '0;
      ram_flags <= '0;
      ram_merge <= 1'b0;
    end else begin
      ram_we  <= 1'b0;
      touch   <= 1'b0;
      set_tag <= 1'b0;
      clr_tag <= 1'b0;
      if (!read) read_ack <= 1'b0;
      if (!write) write_ack <= 1'b0;

      if (waitrequest) begin
        case (state)
          st_idle: begin
            if (hit_slot != '0) begin
              slot <= hit_slot;
              if (write && full_word) begin   // no need to look at the old word
                ram_we    <= 1'b1;
                ram_merge <= 1'b0;
                ram_wdata <= wdata;
                ram_flags <= 2'b11;
              end else begin
                state <= st_hit;
              end
            end else if (free_slot != '0) begin
              slot <= free_slot;
              if (free_tag_valid) begin       // old page still owns it
                wb_cnt  <= '0;
                clr_tag <= 1'b1;
                state   <= st_wb_scan;
              end else begin
                set_tag <= 1'b1;
                state   <= st_hit;
              end
            end else begin                    // all slots busy, go around
              slot      <= '0;
              word_req  <= 1'b1;
              word_we   <= write;
              word_addr <= addr;
              word_data <= wdata;
              word_be   <= write ? be : 4'hf;
              state     <= write ? st_write : st_read;
            end
          end
          st_hit: begin
            if (ram_q[FLAG_V]) begin
              if (write) begin
                ram_we    <= 1'b1;
                ram_merge <= 1'b1;
                ram_wdata <= wdata;
                ram_be    <= be;
                ram_flags <= 2'b11;
              end else begin
                rdata <= ram_q[31:0];
              end
            end else if (write && full_word) begin
              ram_we    <= 1'b1;
              ram_merge <= 1'b0;
              ram_wdata <= wdata;
              ram_flags <= 2'b11;
            end else begin                    // word missing, fetch it
              word_req  <= 1'b1;
              word_we   <= 1'b0;
              word_addr <= addr;
              word_be   <= 4'hf;
              state     <= st_read;
            end
          end
          st_read: begin
            if (word_done) begin
              word_req <= 1'b0;
              if (read) rdata <= rd_word;
              if (slot != '0) begin
                ram_we    <= 1'b1;
                ram_merge <= 1'b0;
                ram_wdata <= write ? merge_bytes(be, wdata, rd_word) : rd_word;
                ram_flags <= {1'b1, write};   // a write leaves it dirty
              end
            end
          end
          st_write: begin
            if (word_done) word_req <= 1'b0;
          end
          st_wb_scan: begin
            if (wb_cnt == 5'(`LINE_WORDS)) begin
              state <= st_wb_done;
            end else begin
              ram_we    <= 1'b1;              // clear entry, lands after the check
              ram_merge <= 1'b0;
              ram_wdata <= '0;
              ram_flags <= 2'b00;
              state     <= st_wb_check;
            end
          end
          st_wb_check: begin
            if (ram_q[FLAG_D]) begin
              word_req  <= 1'b1;
              word_we   <= 1'b1;
              word_addr <= {slot_tag, wb_cnt[`PAGE_W-1:0]};
              word_data <= ram_q[31:0];
              word_be   <= 4'hf;
              state     <= st_wb_exec;
            end else begin
              wb_cnt <= wb_cnt + 1'b1;
              state  <= st_wb_scan;
            end
          end
          st_wb_exec: begin
            if (word_done) begin
              word_req <= 1'b0;
              wb_cnt   <= wb_cnt + 1'b1;
              state    <= st_wb_scan;
            end
          end
          st_wb_done: begin
            set_tag <= 1'b1;                  // slot now belongs to addr's page
            state   <= st_hit;
          end
          default: state <= st_idle;
        endcase
      end

      if (fin) begin
        state     <= st_idle;
        touch     <= (state == st_idle) || (slot != '0);   // bypass leaves lives alone
        read_ack  <= read;
        write_ack <= write;
      end
    end
  end

  a_wait_idle: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $fell(waitrequest) |-> state == st_idle);

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst_n,
  input  logic       read,
  input  logic       write,
  input  addr_t      addr,
  input  word_t      wdata,
  input  be_t        be,
  output word_t      rdata,
  output logic       waitrequest,
  output logic       mem_req,
  output logic       mem_we,
  output mem_addr_t  mem_addr,
  output half_t      mem_wdata,
  output logic [1:0] mem_mask,
  input  half_t      mem_rdata,
  input  logic       mem_ack
);
  logic        word_req;         // word path to mem_port
  logic        word_we;
  addr_t       word_addr;
  word_t       word_data;
  be_t         word_be;
  logic        word_done;
  word_t       rd_word;

  slot_t       slot;             // tag store
  logic        set_tag;
  logic        clr_tag;
  logic        touch;
  slot_t       hit_slot;
  slot_t       free_slot;
  logic        free_tag_valid;
  tag_t        slot_tag;

  logic        ram_we;           // line storage
  idx_t        ram_idx;
  word_t       ram_wdata;
  be_t         ram_be;
  logic [1:0]  ram_flags;
  logic        ram_merge;
  logic [33:0] ram_q;

  cache_ctrl u_ctrl (.*);
  tag_store  u_tags (.*);
  line_ram   u_ram  (.*);
  mem_port   u_mem  (.*);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_mem_model
  import cache_types_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst_n,
  input  logic       mem_req,
  input  logic       mem_we,
  input  mem_addr_t  mem_addr,
  input  half_t      mem_wdata,
  input  logic [1:0] mem_mask,
  output half_t      mem_rdata,
  output logic       mem_ack
);
  typedef enum logic [1:0] {
    ph_idle,
    ph_wait,
    ph_lo,
    ph_hi
  } phase_t;

  half_t     ram [1 << `MEM_ADDR_W];
  phase_t    phase;
  logic      wait_cnt;
  mem_addr_t hi_addr;

  assign hi_addr = mem_addr + 1'b1;   // second beat

  // every halfword starts as a mix of its own address
  initial begin
    for (int a = 0; a < (1 << `MEM_ADDR_W); a++) begin
      ram[a] = (half_t'(a) << 3) ^ half_t'(a) ^ 16'ha5c3;
    end
  end

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      phase     <= ph_idle;
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      wait_cnt  <= 1'b0;
    end else begin
      case (phase)
        ph_idle: begin
          if (mem_req) begin
            wait_cnt <= mem_addr[1];        // some requests take one extra cycle
            phase    <= ph_wait;
          end
        end
        ph_wait: begin
          if (wait_cnt == 1'b0) begin
            mem_ack   <= 1'b1;
            mem_rdata <= ram[mem_addr];
            phase     <= ph_lo;
          end else begin
            wait_cnt <= 1'b0;
          end
        end
        ph_lo: begin
          if (mem_we && !mem_mask[0]) ram[mem_addr][7:0] <= mem_wdata[7:0];
          if (mem_we && !mem_mask[1]) ram[mem_addr][15:8] <= mem_wdata[15:8];
          mem_rdata <= ram[hi_addr];
          phase     <= ph_hi;
        end
        default: begin
          if (mem_we && !mem_mask[0]) ram[hi_addr][7:0] <= mem_wdata[7:0];
          if (mem_we && !mem_mask[1]) ram[hi_addr][15:8] <= mem_wdata[15:8];
          mem_ack <= 1'b0;
          phase   <= ph_idle;
        end
      endcase
    end
  end

endmodule

//--- tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_cache_top
  import cache_types_pkg::*;
();
  localparam int MAX_CYCLES = 400 * 80;
  localparam int WORDS      = 1 << `ADDR_W;
  localparam logic [23:0] BE_SET = 24'h3a_f8_61;   // six byte-enable patterns

  logic       clk;
  logic       sys_rst_n;
  logic       read;
  logic       write;
  addr_t      addr;
  word_t      wdata;
  be_t        be;
  word_t      rdata;
  logic       waitrequest;
  logic       mem_req;
  logic       mem_we;
  mem_addr_t  mem_addr;
  half_t      mem_wdata;
  logic [1:0] mem_mask;
  half_t      mem_rdata;
  logic       mem_ack;

  word_t golden [WORDS];
  word_t exp_rdata;
  int    pass_cnt;
  int    fail_cnt;
  int    test_fail;
  int    cycle_cnt;
  logic  mem_req_seen;
  logic  mem_wr_seen;

  cache_top    DUT (.*);
  tb_mem_model mem (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic half_t init_half(mem_addr_t a);
    return {a, 3'b000} ^ half_t'(a) ^ 16'ha5c3;
  endfunction

  // golden memory, returns the word a read should see
  function automatic word_t ref_access(logic we, addr_t a, word_t d, be_t sel);
    for (int b = 0; b < 4; b++) begin
      if (we && sel[b]) golden[a][8*b +: 8] = d[8*b +: 8];
    end
    return golden[a];
  endfunction

  task automatic report_value(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    fail_cnt  = fail_cnt + 1;
    test_fail = test_fail + 1;
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    fail_cnt  = fail_cnt + 1;
    test_fail = test_fail + 1;
  endtask

  task automatic end_test(input string name);
    if (test_fail == 0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, test_fail);
    test_fail = 0;
  endtask

  task automatic do_access(input logic we, input addr_t a, input word_t d, input be_t sel);
    @(negedge clk);
    exp_rdata    = ref_access(we, a, d, sel);
    mem_req_seen = 1'b0;
    mem_wr_seen  = 1'b0;
    addr  = a;
    wdata = d;
    be    = sel;
    read  = !we;
    write = we;
    @(negedge clk);
    while (waitrequest) @(negedge clk);
    @(negedge clk);                         // one more cycle so the checker sees the ack
    read  = 1'b0;
    write = 1'b0;
  endtask

  // memory traffic seen during the current access
  always @(posedge clk) begin
    if (mem_req) mem_req_seen = 1'b1;
    if (mem_req && mem_we && mem_addr == {addr, 1'b0}) mem_wr_seen = 1'b1;
  end

  always @(posedge clk) begin
    if (sys_rst_n && read && !waitrequest) begin
      if (rdata !== exp_rdata) begin
        report_value($sformatf("read %h gave %h, expected %h", addr, rdata, exp_rdata));
      end else begin
        pass_cnt = pass_cnt + 1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("simulation hung, no end after %0d cycles", MAX_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    word_t       mem_word;
    addr_t       a;
    logic [31:0] rnd;
    int          bypass_cnt;
    sys_rst_n = 1'b0;
    read      = 1'b0;
    write     = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    exp_rdata = '0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_fail = 0;
    mem_req_seen = 1'b0;
    mem_wr_seen  = 1'b0;
    rnd = $urandom(32'h06ff_8074);
    for (int w = 0; w < WORDS; w++) begin
      golden[w] = {init_half({addr_t'(w), 1'b1}), init_half({addr_t'(w), 1'b0})};
    end
    repeat (8) @(negedge clk);
    sys_rst_n = 1'b1;

    for (int i = 0; i < 8; i++) do_access(1'b0, addr_t'(12'h100 + i), '0, 4'hf);
    for (int i = 0; i < 4; i++) do_access(1'b0, addr_t'(12'h110 + 3 * i), '0, 4'hf);
    end_test("test 1 reset contents");

    for (int k = 0; k < 6; k++) begin
      do_access(1'b1, addr_t'(12'h100 + k), $urandom, BE_SET[4*k +: 4]);   // word valid
      do_access(1'b0, addr_t'(12'h100 + k), '0, 4'hf);
      do_access(1'b1, addr_t'(12'h108 + k), $urandom, BE_SET[4*k +: 4]);   // word fetched
      do_access(1'b0, addr_t'(12'h108 + k), '0, 4'hf);
    end
    end_test("test 2 byte merge");

    do_access(1'b0, 12'h10e, '0, 4'hf);
    do_access(1'b0, 12'h10e, '0, 4'hf);
    if (mem_req_seen) report_error("repeated read of 10e went out to memory");
    else pass_cnt = pass_cnt + 1;
    do_access(1'b1, 12'h10f, $urandom, 4'hf);
    if (mem_req_seen) report_error("full-word write to 10f went out to memory");
    else pass_cnt = pass_cnt + 1;
    do_access(1'b0, 12'h10f, '0, 4'hf);
    end_test("test 3 no memory traffic");

    bypass_cnt = 0;
    for (int p = 0; p < 8; p++) begin
      a = {8'h40 + 8'(p), 4'(p)};
      do_access(1'b1, a, $urandom, be_t'($urandom));
      if (mem_wr_seen) begin                // no free slot, went around the cache
        bypass_cnt = bypass_cnt + 1;
        mem_word = {mem.ram[{a, 1'b1}], mem.ram[{a, 1'b0}]};
        if (mem_word !== golden[a]) begin
          report_value($sformatf("memory at %h holds %h, expected %h", a, mem_word, golden[a]));
        end else begin
          pass_cnt = pass_cnt + 1;
        end
      end
    end
    if (bypass_cnt < 4) report_error("fewer than four writes went around a full cache");
    for (int p = 0; p < 8; p++) do_access(1'b0, {8'h40 + 8'(p), 4'(p)}, '0, 4'hf);
    end_test("test 4 full cache");

    for (int n = 0; n < 300; n++) begin
      rnd = $urandom;
      do_access(rnd[8], {5'b00010, rnd[2:0], rnd[7:4]}, $urandom, rnd[12:9]);
    end
    end_test("test 5 random mix");

    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
cache_types_pkg.sv
cache_ctrl_pkg.sv
tag_store.sv
line_ram.sv
mem_port.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_cache_top \
  -o sim_cache_top && ./obj_dir/sim_cache_top | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation run passed" || { echo "simulation run failed"; exit 1; }
